// File: logic/fpu_div_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDIV_NUM_LANES must be a multiple of FDIV_NUM_PES
// FDIV_LATENCY must be at least 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FPU_DIV_MACROS_SVH
`define FPU_DIV_MACROS_SVH

// operand pairs carried by one request
`define FDIV_NUM_LANES 4

// divide PEs shared by the lanes, so a request takes LANES / PES batches
`define FDIV_NUM_PES 2

// enabled cycles from a PE's input to its output
`define FDIV_LATENCY 4

// width of the caller's tag, the lane mask is carried beside it
`define FDIV_TAG_W 8

`endif

// File: logic/fpu_div_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-precision only; rounding codes 4..7 act as RNE
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fpu_div_pkg;

    // rounding mode codes as carried in an instruction
    typedef enum logic [2:0] {
        FRM_RNE = 3'd0,
        FRM_RTZ = 3'd1,
        FRM_RDN = 3'd2,
        FRM_RUP = 3'd3
    } frm_e;

    // exception flags, nv sits in the MSB
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // one lane's inputs to a divide PE
    typedef struct packed {
        frm_e        rm;
        logic [31:0] b;
        logic [31:0] a;
    } div_operands_t;

    // one lane's quotient with its flags
    typedef struct packed {
        fflags_t     fflags;
        logic [31:0] q;
    } div_result_t;

    // every NaN produced by the divider uses this pattern
    localparam logic [31:0] QNAN_CANON = 32'h7FC0_0000;

endpackage

// File: logic/fpu_div_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// subnormal inputs and results flush to signed zero
// result appears FDIV_LATENCY enabled cycles later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fpu_div_macros.svh"

module fpu_div_core import fpu_div_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          enable,
    input  div_operands_t operands,
    output div_result_t   res
);

    logic              sign;
    logic [7:0]        exp_a;
    logic [7:0]        exp_b;
    logic [22:0]       man_a;
    logic [22:0]       man_b;
    logic              zero_a;
    logic              zero_b;
    logic              inf_a;
    logic              inf_b;
    logic              nan_a;
    logic              nan_b;
    logic              snan;
    logic              invalid;
    logic [25:0]       quo;
    logic [25:0]       rem;
    logic [23:0]       mant;
    logic              guard;
    logic              sticky;
    logic              inexact;
    logic              round_up;
    logic              inf_on_of;
    logic [24:0]       mant_r;
    logic signed [9:0] exp_q;
    logic signed [9:0] exp_n;
    logic signed [9:0] exp_r;
    div_result_t       res_d;
    div_result_t       pipe_q [`FDIV_LATENCY];

    always_comb begin
        sign  = operands.a[31] ^ operands.b[31];
        exp_a = operands.a[30:23];
        exp_b = operands.b[30:23];
        man_a = operands.a[22:0];
        man_b = operands.b[22:0];

        // a zero exponent covers subnormals too, which are flushed
        zero_a  = (exp_a == 8'd0);
        zero_b  = (exp_b == 8'd0);
        inf_a   = (exp_a == 8'hff) && (man_a == 23'd0);
        inf_b   = (exp_b == 8'hff) && (man_b == 23'd0);
        nan_a   = (exp_a == 8'hff) && (man_a != 23'd0);
        nan_b   = (exp_b == 8'hff) && (man_b != 23'd0);
        snan    = (nan_a && !man_a[22]) || (nan_b && !man_b[22]);
        invalid = (zero_a && zero_b) || (inf_a && inf_b);

        // restoring division, quo[25] weighs 1 and quo[0] weighs 2^-25
        rem = {2'b00, 1'b1, man_a};
        quo = '0;
        for (int i = 25; i >= 0; i--) begin
            if (rem >= {2'b00, 1'b1, man_b}) begin
                quo[i] = 1'b1;
                rem    = rem - {2'b00, 1'b1, man_b};
            end
            rem = rem << 1;
        end

        exp_q = $signed({2'b00, exp_a}) - $signed({2'b00, exp_b}) + 10'sd127;

        // quotient lies in (0.5, 2) so at most one normalizing shift
        if (quo[25]) begin
            mant   = quo[25:2];
            guard  = quo[1];
            sticky = quo[0] | (rem != 26'd0);
            exp_n  = exp_q;
        end else begin
            mant   = quo[24:1];
            guard  = quo[0];
            sticky = (rem != 26'd0);
            exp_n  = exp_q - 10'sd1;
        end
        inexact = guard | sticky;

        case (operands.rm)
            FRM_RTZ: begin
                round_up  = 1'b0;
                inf_on_of = 1'b0;
            end
            FRM_RDN: begin
                round_up  = sign & inexact;
                inf_on_of = sign;
            end
            FRM_RUP: begin
                round_up  = ~sign & inexact;
                inf_on_of = ~sign;
            end
            default: begin
                round_up  = guard & (sticky | mant[0]);
                inf_on_of = 1'b1;
            end
        endcase

        // a carry out of the mantissa leaves the fraction bits at zero
        mant_r = {1'b0, mant} + 25'(round_up);
        exp_r  = exp_n + $signed({9'd0, mant_r[24]});

        res_d = '0;
        if (nan_a || nan_b || invalid) begin
            res_d.q         = QNAN_CANON;
            res_d.fflags.nv = snan || invalid;
        end else if (inf_a) begin
            res_d.q = {sign, 8'hff, 23'd0};
        end else if (zero_b) begin
            res_d.q         = {sign, 8'hff, 23'd0};
            res_d.fflags.dz = 1'b1;
        end else if (zero_a || inf_b) begin
            res_d.q = {sign, 31'd0};
        end else if (exp_r >= 10'sd255) begin
            // toward zero saturates at the largest finite magnitude
            res_d.q         = inf_on_of ? {sign, 8'hff, 23'd0} : {sign, 8'hfe, {23{1'b1}}};
            res_d.fflags.of = 1'b1;
            res_d.fflags.nx = 1'b1;
        end else if (exp_r <= 10'sd0) begin
            res_d.q         = {sign, 31'd0};
            res_d.fflags.uf = 1'b1;
            res_d.fflags.nx = 1'b1;
        end else begin
            res_d.q         = {sign, exp_r[7:0], mant_r[22:0]};
            res_d.fflags.nx = inexact;
        end
    end

    // delay line freezes whenever enable is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FDIV_LATENCY; i++) begin
                pipe_q[i] <= '0;
            end
        end else if (enable) begin
            pipe_q[0] <= res_d;
            for (int i = 1; i < `FDIV_LATENCY; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign res = pipe_q[`FDIV_LATENCY-1];

endmodule

// File: logic/fpu_pe_serializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one request per (batches + 1) cycles at best
// whole datapath stalls while the output FIFO is full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fpu_div_macros.svh"

module fpu_pe_serializer import fpu_div_pkg::*; #(
    parameter int TAG_W = `FDIV_NUM_LANES + `FDIV_TAG_W
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                valid_in,
    output logic                                ready_in,
    input  div_operands_t [`FDIV_NUM_LANES-1:0] lanes_in,
    input  logic [TAG_W-1:0]                    tag_in,
    output logic                                pe_enable,
    output div_operands_t [`FDIV_NUM_PES-1:0]   pe_operands,
    input  div_result_t [`FDIV_NUM_PES-1:0]     pe_results,
    output logic                                valid_out,
    input  logic                                ready_out,
    output div_result_t [`FDIV_NUM_LANES-1:0]   lanes_out,
    output logic [TAG_W-1:0]                    tag_out
);

    localparam int NL  = `FDIV_NUM_LANES;
    localparam int NP  = `FDIV_NUM_PES;
    localparam int LAT = `FDIV_LATENCY;
    localparam int NB  = NL / NP;
    localparam int CW  = $clog2(NB + 1);
    localparam int BW  = (NB > 1) ? $clog2(NB) : 1;

    typedef struct packed {
        logic             valid;
        logic [BW-1:0]    bidx;
        logic [TAG_W-1:0] tag;
    } track_t;

    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        div_result_t [NL-1:0] lanes;
    } resp_t;

    // 0 means idle, n feeds batch n-1 to the PEs
    logic [CW-1:0]          batch_cnt;
    logic [BW-1:0]          bidx;
    div_operands_t [NL-1:0] req_q;
    logic [TAG_W-1:0]       req_tag_q;
    track_t                 trk_in;
    track_t                 trk_q [LAT];
    track_t                 trk_out;
    div_result_t [NL-1:0]   coll_q;
    div_result_t [NL-1:0]   coll_d;
    resp_t                  push_data;
    resp_t                  fifo_q [2];
    logic                   push;
    logic                   pop;
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;

    assign pe_enable = (count != 2'd2);
    assign ready_in  = pe_enable && (batch_cnt == '0);
    assign bidx      = BW'(batch_cnt - CW'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            batch_cnt <= '0;
        end else if (pe_enable) begin
            if (batch_cnt == '0) begin
                if (valid_in) begin
                    batch_cnt <= CW'(1);
                end
            end else if (batch_cnt == CW'(NB)) begin
                batch_cnt <= '0;
            end else begin
                batch_cnt <= batch_cnt + CW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && ready_in) begin
            req_q     <= lanes_in;
            req_tag_q <= tag_in;
        end
    end

    always_comb begin
        for (int i = 0; i < NP; i++) begin
            pe_operands[i] = req_q[int'(bidx) * NP + i];
        end
    end

    // tracker runs beside the PEs under the same enable
    assign trk_in = '{valid: (batch_cnt != '0), bidx: bidx, tag: req_tag_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT; i++) begin
                trk_q[i].valid <= 1'b0;
            end
        end else if (pe_enable) begin
            trk_q[0] <= trk_in;
            for (int i = 1; i < LAT; i++) begin
                trk_q[i] <= trk_q[i-1];
            end
        end
    end

    assign trk_out = trk_q[LAT-1];

    always_comb begin
        coll_d = coll_q;
        if (trk_out.valid) begin
            for (int i = 0; i < NP; i++) begin
                coll_d[int'(trk_out.bidx) * NP + i] = pe_results[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pe_enable) begin
            coll_q <= coll_d;
        end
    end

    // the last batch completes the response in the same cycle it lands
    assign push            = pe_enable && trk_out.valid && (trk_out.bidx == BW'(NB - 1));
    assign pop             = valid_out && ready_out;
    assign push_data.tag   = trk_out.tag;
    assign push_data.lanes = coll_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_q[wr_ptr] <= push_data;
        end
    end

    assign valid_out = (count != 2'd0);
    assign lanes_out = fifo_q[rd_ptr].lanes;
    assign tag_out   = fifo_q[rd_ptr].tag;

endmodule

// File: logic/fpu_div.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fflags merges inactive lanes out; result keeps all lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fpu_div_macros.svh"

module fpu_div import fpu_div_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_in,
    output logic                             ready_in,
    input  logic [`FDIV_NUM_LANES-1:0]       mask,
    input  logic [`FDIV_TAG_W-1:0]           tag,
    input  frm_e                             rm,
    input  logic [`FDIV_NUM_LANES-1:0][31:0] dataa,
    input  logic [`FDIV_NUM_LANES-1:0][31:0] datab,
    output logic                             valid_out,
    input  logic                             ready_out,
    output logic [`FDIV_NUM_LANES-1:0][31:0] result,
    output fflags_t                          fflags,
    output logic [`FDIV_TAG_W-1:0]           tag_out
);

    div_operands_t [`FDIV_NUM_LANES-1:0] lanes_in;
    div_result_t [`FDIV_NUM_LANES-1:0]   lanes_out;
    div_operands_t [`FDIV_NUM_PES-1:0]   pe_operands;
    div_result_t [`FDIV_NUM_PES-1:0]     pe_results;
    logic                                pe_enable;
    logic [`FDIV_NUM_LANES-1:0]          mask_out;
    logic [4:0]                          flags_acc;

    // one rounding mode applies to every lane of a request
    always_comb begin
        for (int i = 0; i < `FDIV_NUM_LANES; i++) begin
            lanes_in[i].a  = dataa[i];
            lanes_in[i].b  = datab[i];
            lanes_in[i].rm = rm;
        end
    end

    fpu_pe_serializer #(
        .TAG_W (`FDIV_NUM_LANES + `FDIV_TAG_W)
    ) i_serializer (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .ready_in    (ready_in),
        .lanes_in    (lanes_in),
        .tag_in      ({mask, tag}),
        .pe_enable   (pe_enable),
        .pe_operands (pe_operands),
        .pe_results  (pe_results),
        .valid_out   (valid_out),
        .ready_out   (ready_out),
        .lanes_out   (lanes_out),
        .tag_out     ({mask_out, tag_out})
    );

    for (genvar p = 0; p < `FDIV_NUM_PES; p++) begin : g_pe
        fpu_div_core i_core (
            .clk      (clk),
            .rst_n    (rst_n),
            .enable   (pe_enable),
            .operands (pe_operands[p]),
            .res      (pe_results[p])
        );
    end

    always_comb begin
        flags_acc = '0;
        for (int i = 0; i < `FDIV_NUM_LANES; i++) begin
            result[i] = lanes_out[i].q;
            if (mask_out[i]) begin
                flags_acc = flags_acc | lanes_out[i].fflags;
            end
        end
    end

    assign fflags = flags_acc;

endmodule

// File: verif/fpu_div_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// samples on the rising edge; fail_count totals all failures
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fpu_div_macros.svh"

module fpu_div_assertions import fpu_div_pkg::*; (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             ready_in,
    input logic                             valid_out,
    input logic                             ready_out,
    input logic [`FDIV_NUM_LANES-1:0][31:0] result,
    input fflags_t                          fflags,
    input logic [`FDIV_TAG_W-1:0]           tag_out
);

    timeunit 1ns;
    timeprecision 100ps;

    int reset_fails = 0;
    int stall_fails = 0;
    int x_fails = 0;
    int fail_count;

    assign fail_count = reset_fails + stall_fails + x_fails;

    // one reset cycle leaves the FIFO empty and the input side open
    reset_state: assert property (@(posedge clk) !rst_n |=> (!valid_out && ready_in))
        else begin
            reset_fails++;
            $error("valid_out high or ready_in low right after reset");
        end

    // a held response keeps every output unchanged
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && !ready_out) |=>
        (valid_out && $stable(result) && $stable(fflags) && $stable(tag_out)))
        else begin
            stall_fails++;
            $error("response changed or dropped while ready_out was low");
        end

    no_unknown: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> !$isunknown({result, fflags, tag_out}))
        else begin
            x_fails++;
            $error("unknown bits on the outputs while valid_out is high");
        end

endmodule

bind fpu_div fpu_div_assertions i_assertions (.*);

// File: verif/fpu_div_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// the case table assumes FDIV_NUM_LANES is 4
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fpu_div_macros.svh"

module fpu_div_tb import fpu_div_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NL = `FDIV_NUM_LANES;
    localparam int NT = 8;
    localparam int NUM_BURST = 40;
    localparam int NUM_REQ = NT + NUM_BURST;
    localparam int WATCHDOG_NS = NUM_REQ * (`FDIV_LATENCY + 2 + 20) * 10;

    typedef struct packed {
        logic [NL-1:0][31:0]      q;
        fflags_t                  flags;
        logic [`FDIV_TAG_W-1:0]   tag;
        logic [3:0]               tmpl;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    logic                   valid_in;
    logic                   ready_in;
    logic [NL-1:0]          mask;
    logic [`FDIV_TAG_W-1:0] tag;
    frm_e                   rm;
    logic [NL-1:0][31:0]    dataa;
    logic [NL-1:0][31:0]    datab;
    logic                   valid_out;
    logic                   ready_out;
    logic [NL-1:0][31:0]    result;
    fflags_t                fflags;
    logic [`FDIV_TAG_W-1:0] tag_out;

    frm_e        tmpl_rm [NT];
    logic [31:0] tmpl_a [NT][NL];
    logic [31:0] tmpl_b [NT][NL];
    logic [31:0] tmpl_q [NT][NL];
    fflags_t     tmpl_f [NT][NL];
    string       tmpl_name [NT];
    expect_t     exp_q [$];
    logic        stall_en = 1'b0;
    int          errors = 0;
    int          n_resp = 0;
    int          total;

    fpu_div i_fpu_div (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic set_lane(input int t, input int l, input frm_e r,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] q, input logic [4:0] f);
        tmpl_rm[t]   = r;
        tmpl_a[t][l] = a;
        tmpl_b[t][l] = b;
        tmpl_q[t][l] = q;
        tmpl_f[t][l] = f;
    endtask

    // flags column is {nv, dz, of, uf, nx}
    task automatic init_cases();
        tmpl_name = '{"exact", "round_rne", "round_rtz", "round_rdn", "round_rup",
                      "special", "range", "mask_merge"};
        set_lane(0, 0, FRM_RNE, 32'h40C0_0000, 32'h4040_0000, 32'h4000_0000, 5'b00000);
        set_lane(0, 1, FRM_RNE, 32'h3F80_0000, 32'h4080_0000, 32'h3E80_0000, 5'b00000);
        set_lane(0, 2, FRM_RNE, 32'hC100_0000, 32'h4000_0000, 32'hC080_0000, 5'b00000);
        set_lane(0, 3, FRM_RNE, 32'h4040_0000, 32'h3F00_0000, 32'h40C0_0000, 5'b00000);
        set_lane(1, 0, FRM_RNE, 32'h3F80_0000, 32'h4040_0000, 32'h3EAA_AAAB, 5'b00001);
        set_lane(1, 1, FRM_RNE, 32'hBF80_0000, 32'h4040_0000, 32'hBEAA_AAAB, 5'b00001);
        set_lane(1, 2, FRM_RNE, 32'h40C0_0000, 32'h4040_0000, 32'h4000_0000, 5'b00000);
        set_lane(1, 3, FRM_RNE, 32'h3F80_0000, 32'h4080_0000, 32'h3E80_0000, 5'b00000);
        set_lane(2, 0, FRM_RTZ, 32'h3F80_0000, 32'h4040_0000, 32'h3EAA_AAAA, 5'b00001);
        set_lane(2, 1, FRM_RTZ, 32'hBF80_0000, 32'h4040_0000, 32'hBEAA_AAAA, 5'b00001);
        set_lane(2, 2, FRM_RTZ, 32'h7F7F_FFFF, 32'h3F00_0000, 32'h7F7F_FFFF, 5'b00101);
        set_lane(2, 3, FRM_RTZ, 32'h3F80_0000, 32'h4080_0000, 32'h3E80_0000, 5'b00000);
        set_lane(3, 0, FRM_RDN, 32'h3F80_0000, 32'h4040_0000, 32'h3EAA_AAAA, 5'b00001);
        set_lane(3, 1, FRM_RDN, 32'hBF80_0000, 32'h4040_0000, 32'hBEAA_AAAB, 5'b00001);
        set_lane(3, 2, FRM_RDN, 32'h40C0_0000, 32'h4040_0000, 32'h4000_0000, 5'b00000);
        set_lane(3, 3, FRM_RDN, 32'h4040_0000, 32'h3F00_0000, 32'h40C0_0000, 5'b00000);
        set_lane(4, 0, FRM_RUP, 32'h3F80_0000, 32'h4040_0000, 32'h3EAA_AAAB, 5'b00001);
        set_lane(4, 1, FRM_RUP, 32'hBF80_0000, 32'h4040_0000, 32'hBEAA_AAAA, 5'b00001);
        set_lane(4, 2, FRM_RUP, 32'hC100_0000, 32'h4000_0000, 32'hC080_0000, 5'b00000);
        set_lane(4, 3, FRM_RUP, 32'h3F80_0000, 32'h4080_0000, 32'h3E80_0000, 5'b00000);
        set_lane(5, 0, FRM_RNE, 32'h3F80_0000, 32'h0000_0000, 32'h7F80_0000, 5'b01000);
        set_lane(5, 1, FRM_RNE, 32'h0000_0000, 32'h0000_0000, QNAN_CANON, 5'b10000);
        set_lane(5, 2, FRM_RNE, 32'h7F80_0000, 32'h7F80_0000, QNAN_CANON, 5'b10000);
        set_lane(5, 3, FRM_RNE, 32'hC0A0_0000, 32'h7F80_0000, 32'h8000_0000, 5'b00000);
        set_lane(6, 0, FRM_RNE, 32'h7F7F_FFFF, 32'h3F00_0000, 32'h7F80_0000, 5'b00101);
        set_lane(6, 1, FRM_RNE, 32'h0080_0000, 32'h4080_0000, 32'h0000_0000, 5'b00011);
        set_lane(6, 2, FRM_RNE, 32'h0000_0001, 32'h4000_0000, 32'h0000_0000, 5'b00000);
        set_lane(6, 3, FRM_RNE, 32'h3F80_0000, 32'h8000_0000, 32'hFF80_0000, 5'b01000);
        set_lane(7, 0, FRM_RNE, 32'h40C0_0000, 32'h4040_0000, 32'h4000_0000, 5'b00000);
        set_lane(7, 1, FRM_RNE, 32'h3F80_0000, 32'h0000_0000, 32'h7F80_0000, 5'b01000);
        set_lane(7, 2, FRM_RNE, 32'h3F80_0000, 32'h4040_0000, 32'h3EAA_AAAB, 5'b00001);
        set_lane(7, 3, FRM_RNE, 32'h3F80_0000, 32'h4080_0000, 32'h3E80_0000, 5'b00000);
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic send_req(input int t, input logic [NL-1:0] m,
                            input logic [`FDIV_TAG_W-1:0] tg);
        expect_t e;
        e.flags = '0;
        e.tag   = tg;
        e.tmpl  = 4'(t);
        for (int l = 0; l < NL; l++) begin
            e.q[l]   = tmpl_q[t][l];
            dataa[l] = tmpl_a[t][l];
            datab[l] = tmpl_b[t][l];
            if (m[l]) begin
                e.flags = e.flags | tmpl_f[t][l];
            end
        end
        exp_q.push_back(e);
        mask     = m;
        tag      = tg;
        rm       = tmpl_rm[t];
        valid_in = 1'b1;
        while (!ready_in) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    // during the burst the sink drains slower than requests arrive, so the FIFO fills
    initial begin
        ready_out = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            ready_out = stall_en ? ($urandom_range(3, 0) == 0) : 1'b1;
        end
    end

    // outputs are stable at the falling edge, so a transfer is seen here
    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            if (valid_out && ready_out) begin
                n_resp++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a response arrived with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    assert (result == e.q) else begin
                        errors++;
                        $display("ERR %s result: expected %h, actual %h",
                                 tmpl_name[e.tmpl], e.q, result);
                    end
                    assert (fflags == e.flags) else begin
                        errors++;
                        $display("ERR %s fflags: expected %b, actual %b",
                                 tmpl_name[e.tmpl], e.flags, fflags);
                    end
                    assert (tag_out == e.tag) else begin
                        errors++;
                        $display("ERR %s tag_out: expected %h, actual %h",
                                 tmpl_name[e.tmpl], e.tag, tag_out);
                    end
                end
            end
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired with %0d of %0d responses received", n_resp, NUM_REQ);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(73767));
        rst_n    = 1'b0;
        valid_in = 1'b0;
        mask     = '0;
        tag      = '0;
        rm       = FRM_RNE;
        dataa    = '0;
        datab    = '0;
        init_cases();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // the mask_merge case hides its divide-by-zero lane
        for (int t = 0; t < NT; t++) begin
            send_req(t, (t == 7) ? 4'b1101 : 4'b1111, 8'($urandom()));
        end
        stall_en = 1'b1;
        for (int n = 0; n < NUM_BURST; n++) begin
            send_req($urandom_range(NT - 1, 0), 4'($urandom()), 8'($urandom()));
        end
        while (n_resp < NUM_REQ) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        total = errors + i_fpu_div.i_assertions.fail_count;
        $display("responses %0d of %0d, check errors %0d, assertion failures %0d",
                 n_resp, NUM_REQ, errors, i_fpu_div.i_assertions.fail_count);
        if (total == 0 && n_resp == NUM_REQ) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/fpu_div_pkg.sv
logic/fpu_div_core.sv
logic/fpu_pe_serializer.sv
logic/fpu_div.sv
verif/fpu_div_assertions.sv
verif/fpu_div_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the fpu_div testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module fpu_div_tb -o sim_fpu_div

# a high error limit keeps the run going past assertion failures
obj_dir/sim_fpu_div +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
